/* design/pitch_macros.svh */
`ifndef PITCH_MACROS_SVH
`define PITCH_MACROS_SVH

// voices and oscillators per voice
`define PITCH_VOICES 8
`define PITCH_OSCS 4

// index widths
`define PITCH_V_W 3
`define PITCH_O_W 2

// field offsets inside one oscillator's 16-address block
`define PITCH_ADR_CT 0
`define PITCH_ADR_FT 1
`define PITCH_ADR_KS 5
`define PITCH_ADR_BCT 8
`define PITCH_ADR_BFT 9

// common space
`define PITCH_ADR_PBR 0

`endif

/* design/pitch_pkg.sv */
`include "pitch_macros.svh"

package pitch_pkg;

    // scanned voice/oscillator slot
    typedef struct packed {
        logic [`PITCH_V_W-1:0] voice;
        logic [`PITCH_O_W-1:0] osc;
    } slot_t;

    // oscillator view of the bus address
    typedef struct packed {
        logic [2:0] num;    // top bit unused
        logic [3:0] field;
    } osc_adr_t;

    typedef union packed {
        osc_adr_t   osc;
        logic [6:0] com;    // common space index
    } param_adr_u;

    typedef struct packed {
        logic [7:0] ct;     // m:c coarse ratio
        logic [7:0] ft;     // ratio fine transpose
        logic [7:0] ks;     // key scale
        logic [7:0] bct;    // base coarse
        logic [7:0] bft;    // base fine
    } osc_param_t;

    // top octave increments, semitones 0..11
    parameter logic [23:0] base_octave [12] = '{
        24'h400000,
        24'h43CE3F,
        24'h47D66B,
        24'h4C1BF8,
        24'h50A28C,
        24'h556E04,
        24'h5A827A,
        24'h5FE443,
        24'h6597FB,
        24'h6BA27E,
        24'h7208F8,
        24'h78D0E0
    };

endpackage

/* design/key_table.sv */
`timescale 1ns/1ps
`include "pitch_macros.svh"

module key_table (
    input  logic                    sCLK_XVXOSC,
    input  logic                    reset_data_N,
    input  logic                    note_on,
    input  logic [`PITCH_V_W-1:0]   key_voice,
    input  logic [7:0]              key_val,
    input  logic [`PITCH_V_W-1:0]   rd_voice,
    output logic [7:0]              key
);

    logic [7:0] keys [`PITCH_VOICES];

    always_ff @(posedge sCLK_XVXOSC) begin
        if (!reset_data_N) begin
            for (int v = 0; v < `PITCH_VOICES; v++) begin
                keys[v] <= 8'hFF;   // no note held
            end
        end else if (note_on) begin
            keys[key_voice] <= key_val;
        end
    end

    // scanned voice
    assign key = keys[rd_voice];

endmodule

/* design/pitch_param_regs.sv */
`timescale 1ns/1ps
`include "pitch_macros.svh"

module pitch_param_regs (
    input  logic                    sCLK_XVXOSC,
    input  logic                    reset_data_N,
    input  logic                    osc_sel,
    input  logic                    com_sel,
    input  pitch_pkg::param_adr_u   adr,
    input  logic [7:0]              wdata,
    input  logic                    wr,
    input  logic                    rd,
    output logic [7:0]              rdata,
    input  logic [`PITCH_O_W-1:0]   osc_a,
    output pitch_pkg::osc_param_t   par_a,
    input  logic [`PITCH_O_W-1:0]   osc_b,
    output pitch_pkg::osc_param_t   par_b,
    output logic [7:0]              pb_range
);

    pitch_pkg::osc_param_t  regs [`PITCH_OSCS];
    logic [`PITCH_O_W-1:0]  sel_osc;
    logic                   osc_space;
    logic                   com_hit;
    logic [7:0]             rd_byte;

    assign sel_osc   = adr.osc.num[`PITCH_O_W-1:0];
    assign osc_space = osc_sel && (adr.osc.num[2:`PITCH_O_W] == '0);
    assign com_hit   = !osc_sel && com_sel && (adr.com == 7'(`PITCH_ADR_PBR));

    always_comb begin
        rd_byte = 8'h00;    // holes
        if (osc_space) begin
            case (adr.osc.field)
                4'(`PITCH_ADR_CT):  rd_byte = regs[sel_osc].ct;
                4'(`PITCH_ADR_FT):  rd_byte = regs[sel_osc].ft;
                4'(`PITCH_ADR_KS):  rd_byte = regs[sel_osc].ks;
                4'(`PITCH_ADR_BCT): rd_byte = regs[sel_osc].bct;
                4'(`PITCH_ADR_BFT): rd_byte = regs[sel_osc].bft;
                default:            rd_byte = 8'h00;
            endcase
        end else if (com_hit) begin
            rd_byte = pb_range;
        end
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        if (!reset_data_N) begin
            for (int o = 0; o < `PITCH_OSCS; o++) begin
                regs[o] <= '{ct: 8'h40, ft: 8'h40, ks: 8'h00, bct: 8'h40, bft: 8'h40};
            end
            pb_range <= 8'd3;   // semitones
            rdata    <= 8'h00;
        end else begin
            if (wr && osc_space) begin
                case (adr.osc.field)
                    4'(`PITCH_ADR_CT):  regs[sel_osc].ct  <= wdata;
                    4'(`PITCH_ADR_FT):  regs[sel_osc].ft  <= wdata;
                    4'(`PITCH_ADR_KS):  regs[sel_osc].ks  <= wdata;
                    4'(`PITCH_ADR_BCT): regs[sel_osc].bct <= wdata;
                    4'(`PITCH_ADR_BFT): regs[sel_osc].bft <= wdata;
                    default: ;
                endcase
            end else if (wr && com_hit) begin
                pb_range <= wdata;
            end
            if (rd) begin
                rdata <= rd_byte;   // held until next rd
            end
        end
    end

    // stage 0 and stage 1 lookups
    assign par_a = regs[osc_a];
    assign par_b = regs[osc_b];

endmodule

/* design/note_freq_rom.sv */
`timescale 1ns/1ps

module note_freq_rom (
    input  logic        sCLK_XVXOSC,
    input  logic [8:0]  note,
    output logic [23:0] incr
);

    // octave 21 semitone 11 is the unshifted top entry
    localparam int TOP_NOTE = 263;

    logic [8:0] n_clamp;
    logic [4:0] octave;
    logic [3:0] semi;
    logic [4:0] shift;

    always_comb begin
        n_clamp = (note > 9'(TOP_NOTE)) ? 9'(TOP_NOTE) : note;
        octave  = 5'(n_clamp / 9'd12);
        semi    = 4'(n_clamp % 9'd12);
        shift   = 5'd21 - octave;   // 21 down to 0
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        incr <= pitch_pkg::base_octave[semi] >> shift;
    end

endmodule

/* design/pitch_calc.sv */
`timescale 1ns/1ps
`include "pitch_macros.svh"

module pitch_calc (
    input  logic                    sCLK_XVXOSC,
    input  logic                    reset_data_N,
    input  pitch_pkg::slot_t        slot,
    input  logic [7:0]              key,
    input  pitch_pkg::osc_param_t   par0,
    input  pitch_pkg::osc_param_t   par1,
    input  logic [13:0]             pitch_bend,
    input  logic [7:0]              pb_range,
    output logic [`PITCH_O_W-1:0]   osc_a,
    output logic [`PITCH_O_W-1:0]   osc_b,
    output logic [`PITCH_V_W-1:0]   rd_voice,
    output logic [23:0]             osc_pitch,
    output pitch_pkg::slot_t        out_slot,
    output logic                    out_valid
);

    // floor at 0, ceiling at 511
    function automatic logic [8:0] to_note(input logic signed [10:0] n);
        logic [8:0] r;
        if (n < 0) r = '0;
        else if (n > 11'sd511) r = 9'd511;
        else r = n[8:0];
        return r;
    endfunction

    logic signed [10:0] b_off, base_note, ft_note, pb_dist, pb_note, pbn_note;
    logic               bend_dn0;
    logic [23:0]        ct_res, ft_res, pb_res, pbn_res;
    pitch_pkg::slot_t   s1_slot, s2_slot, s3_slot;
    logic [13:0]        s1_bend;

    logic               ft_dn, bend_dn1;
    logic [6:0]         ft_w;
    logic [30:0]        ft_prod, pb_fprod;
    logic [23:0]        ft_pitch, pb_semi, pb_tuned, full_pitch, base_pitch;
    logic [13:0]        bend_w;
    logic signed [24:0] bend_diff;
    logic signed [39:0] bend_prod;
    logic [6:0]         ratio, ratio_lo, ratio_hi;

    logic [23:0]        s2_base, s2_q, s2_ql, s2_qh;
    logic [6:0]         s2_ratio;
    logic [7:0]         s2_ct, s2_ft;
    logic [30:0]        res, res_l, res_h;
    logic [30:0]        s3_res, s3_res_l, s3_res_h;
    logic [7:0]         s3_ft;
    logic               tr_dn;
    logic [6:0]         tr_w;
    logic [37:0]        tr_prod, tr_sum;
    logic [3:0]         v_pipe;

    assign rd_voice = slot.voice;
    assign osc_a    = slot.osc;
    assign osc_b    = s1_slot.osc;  // stage 1 oscillator

    // stage 0: note numbers
    always_comb begin
        b_off = (par0.bct <= 8'd63) ? $signed({3'b0, par0.bct}) - 11'sd64
                                    : $signed({5'b0, par0.bct[5:0]});
        base_note = $signed({3'b0, key}) + 11'sd128 + b_off;
        ft_note   = (par0.bft <= 8'd63) ? base_note - 11'sd1 : base_note + 11'sd1;
        bend_dn0  = pitch_bend <= 14'h1FFF;
        pb_dist   = $signed({3'b0, pb_range});
        pb_note   = bend_dn0 ? base_note - pb_dist : base_note + pb_dist;
        pbn_note  = bend_dn0 ? base_note - pb_dist - 11'sd1 : base_note + pb_dist + 11'sd1;
    end

    note_freq_rom u_rom_ct  (.sCLK_XVXOSC(sCLK_XVXOSC), .note(to_note(base_note)), .incr(ct_res));
    note_freq_rom u_rom_ft  (.sCLK_XVXOSC(sCLK_XVXOSC), .note(to_note(ft_note)),   .incr(ft_res));
    note_freq_rom u_rom_pb  (.sCLK_XVXOSC(sCLK_XVXOSC), .note(to_note(pb_note)),   .incr(pb_res));
    note_freq_rom u_rom_pbn (.sCLK_XVXOSC(sCLK_XVXOSC), .note(to_note(pbn_note)),  .incr(pbn_res));

    always_ff @(posedge sCLK_XVXOSC) begin
        s1_slot <= slot;
        s1_bend <= pitch_bend;
    end

    // stage 1: fine tune, bend, key scale, divide
    always_comb begin
        ft_dn    = par1.bft <= 8'd63;
        ft_w     = ft_dn ? 7'd64 - par1.bft[6:0] : {1'b0, par1.bft[5:0]};
        ft_prod  = ft_dn ? (ct_res - ft_res) * ft_w : (ft_res - ct_res) * ft_w;
        ft_pitch = ft_dn ? ct_res - 24'(ft_prod >> 6) : ct_res + 24'(ft_prod >> 6);

        bend_dn1 = s1_bend <= 14'h1FFF;
        pb_semi  = bend_dn1 ? pb_res - pbn_res : pbn_res - pb_res;
        pb_fprod = pb_semi * ft_w;  // same fine offset at the bend target
        pb_tuned = ft_dn ? pb_res - 24'(pb_fprod >> 6) : pb_res + 24'(pb_fprod >> 6);

        bend_w     = bend_dn1 ? 14'h2000 - s1_bend : {1'b0, s1_bend[12:0]};
        bend_diff  = $signed({1'b0, pb_tuned}) - $signed({1'b0, ft_pitch});
        bend_prod  = bend_diff * $signed({1'b0, bend_w});
        full_pitch = 24'($signed({16'b0, ft_pitch}) + (bend_prod >>> 13));
        base_pitch = full_pitch + {12'b0, par1.ks, 4'b0};

        ratio    = (par1.ct <= 8'd64) ? 7'd65 - par1.ct[6:0] : {1'b0, par1.ct[5:0]} + 7'd1;
        ratio_lo = ratio + 7'd1;
        ratio_hi = (ratio == 7'd1) ? 7'd1 : ratio - 7'd1;   // unused at 0x40
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        s2_base  <= base_pitch;
        s2_ratio <= ratio;
        s2_q     <= base_pitch / ratio;
        s2_ql    <= base_pitch / ratio_lo;
        s2_qh    <= base_pitch / ratio_hi;
        s2_ct    <= par1.ct;
        s2_ft    <= par1.ft;
        s2_slot  <= s1_slot;
    end

    // stage 2: divide or multiply
    always_comb begin
        res   = (s2_ct <= 8'd64) ? {7'b0, s2_q}  : s2_base * s2_ratio;
        res_l = (s2_ct <= 8'd64) ? {7'b0, s2_ql} : s2_base * (s2_ratio - 7'd1);
        res_h = (s2_ct <= 8'd63) ? {7'b0, s2_qh} : s2_base * (s2_ratio + 7'd1);
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        s3_res   <= res;
        s3_res_l <= res_l;
        s3_res_h <= res_h;
        s3_ft    <= s2_ft;
        s3_slot  <= s2_slot;
    end

    // stage 3: fine transpose between ratio neighbours
    always_comb begin
        tr_dn   = s3_ft <= 8'h40;
        tr_w    = tr_dn ? 7'd64 - s3_ft[6:0] : {1'b0, s3_ft[5:0]};
        tr_prod = tr_dn ? (s3_res - s3_res_l) * tr_w : (s3_res_h - s3_res) * tr_w;
        tr_sum  = tr_dn ? s3_res - (tr_prod >> 6) : s3_res + (tr_prod >> 6);
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        osc_pitch <= (|tr_sum[37:24]) ? 24'hFFFFFF : tr_sum[23:0];  // saturate
        out_slot  <= s3_slot;
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        if (!reset_data_N) begin
            v_pipe <= '0;
        end else begin
            v_pipe <= {v_pipe[2:0], 1'b1};
        end
    end

    assign out_valid = v_pipe[3];

endmodule

/* design/pitch_control_top.sv */
`timescale 1ns/1ps
`include "pitch_macros.svh"

module pitch_control_top (
    input  logic                    sCLK_XVXOSC,
    input  logic                    reset_data_N,
    input  logic                    osc_sel,
    input  logic                    com_sel,
    input  pitch_pkg::param_adr_u   adr,
    input  logic [7:0]              wdata,
    input  logic                    wr,
    input  logic                    rd,
    input  logic [`PITCH_V_W-1:0]   key_voice,
    input  logic [7:0]              key_val,
    input  logic                    note_on,
    input  pitch_pkg::slot_t        slot,
    input  logic [13:0]             pitch_bend,
    output logic [7:0]              rdata,
    output logic [23:0]             osc_pitch,
    output pitch_pkg::slot_t        out_slot,
    output logic                    out_valid
);

    logic [7:0]             key;
    logic [`PITCH_V_W-1:0]  rd_voice;
    logic [`PITCH_O_W-1:0]  osc_a;
    logic [`PITCH_O_W-1:0]  osc_b;
    pitch_pkg::osc_param_t  par_a;
    pitch_pkg::osc_param_t  par_b;
    logic [7:0]             pb_range;

    key_table u_keys (
        .sCLK_XVXOSC  (sCLK_XVXOSC),
        .reset_data_N (reset_data_N),
        .note_on      (note_on),
        .key_voice    (key_voice),
        .key_val      (key_val),
        .rd_voice     (rd_voice),
        .key          (key)
    );

    pitch_param_regs u_regs (
        .sCLK_XVXOSC  (sCLK_XVXOSC),
        .reset_data_N (reset_data_N),
        .osc_sel      (osc_sel),
        .com_sel      (com_sel),
        .adr          (adr),
        .wdata        (wdata),
        .wr           (wr),
        .rd           (rd),
        .rdata        (rdata),
        .osc_a        (osc_a),
        .par_a        (par_a),
        .osc_b        (osc_b),
        .par_b        (par_b),
        .pb_range     (pb_range)
    );

    pitch_calc u_calc (
        .sCLK_XVXOSC  (sCLK_XVXOSC),
        .reset_data_N (reset_data_N),
        .slot         (slot),
        .key          (key),
        .par0         (par_a),
        .par1         (par_b),
        .pitch_bend   (pitch_bend),
        .pb_range     (pb_range),
        .osc_a        (osc_a),
        .osc_b        (osc_b),
        .rd_voice     (rd_voice),
        .osc_pitch    (osc_pitch),
        .out_slot     (out_slot),
        .out_valid    (out_valid)
    );

endmodule

/* bench/pitch_chk.sv */
`timescale 1ns/1ps
`include "pitch_macros.svh"

module pitch_chk (
    input logic                    sCLK_XVXOSC,
    input logic                    reset_data_N,
    input logic                    osc_sel,
    input logic                    com_sel,
    input pitch_pkg::param_adr_u   adr,
    input logic [7:0]              wdata,
    input logic                    wr,
    input logic                    rd,
    input logic [`PITCH_V_W-1:0]   key_voice,
    input logic [7:0]              key_val,
    input logic                    note_on,
    input pitch_pkg::slot_t        slot,
    input logic [13:0]             pitch_bend,
    input logic [7:0]              rdata,
    input logic [23:0]             osc_pitch,
    input pitch_pkg::slot_t        out_slot,
    input logic                    out_valid
);

    int                     fail_cnt = 0;
    logic                   started = 1'b0;
    logic [7:0]             keys [`PITCH_VOICES];
    logic [7:0]             mem [`PITCH_OSCS][16];     // register map mirror
    logic [7:0]             pbr;
    logic [7:0]             exp_rdata;
    logic [2:0]             rcnt;
    pitch_pkg::osc_param_t  cur_par;
    logic                   cur_ok;
    logic                   busy;
    logic [23:0]            exp_val [4];
    pitch_pkg::slot_t       exp_slot [4];
    logic [3:0]             exp_chk = '0;
    logic [3:0]             exp_full = '0;

    function automatic logic mapped(input logic [3:0] f);
        return f inside {`PITCH_ADR_CT, `PITCH_ADR_FT, `PITCH_ADR_KS,
                         `PITCH_ADR_BCT, `PITCH_ADR_BFT};
    endfunction

    // note number to shifted top octave entry
    function automatic logic [23:0] rom(input int n);
        int c;
        c = (n < 0) ? 0 : ((n > 263) ? 263 : n);
        return pitch_pkg::base_octave[c % 12] >> (21 - c / 12);
    endfunction

    function automatic logic [23:0] expect_pitch(input logic [7:0] k,
                                                 input pitch_pkg::osc_param_t p,
                                                 input logic [7:0] pr, input logic bend0);
        int          note;
        logic [31:0] v;
        note = k + 128 + ((p.bct <= 8'd63) ? int'(p.bct) - 64 : int'(p.bct[5:0]));
        if (bend0) note = note - int'(pr);  // full bend down
        v = rom(note) + p.ks * 16;
        if (p.ct > 8'h40) v = v * (p.ct[5:0] + 1);
        else v = v / (65 - int'(p.ct));
        return (v > 32'hFFFFFF) ? 24'hFFFFFF : v[23:0];
    endfunction

    always_comb begin
        cur_par.ct  = mem[slot.osc][`PITCH_ADR_CT];
        cur_par.ft  = mem[slot.osc][`PITCH_ADR_FT];
        cur_par.ks  = mem[slot.osc][`PITCH_ADR_KS];
        cur_par.bct = mem[slot.osc][`PITCH_ADR_BCT];
        cur_par.bft = mem[slot.osc][`PITCH_ADR_BFT];
        cur_ok = started && reset_data_N && cur_par.ft == 8'h40 && cur_par.bft == 8'h40
                 && (pitch_bend == 14'h2000 || pitch_bend == 14'h0000);
        busy   = wr || note_on; // spoils slots in flight
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        started <= 1'b1;
        if (!reset_data_N) begin
            for (int v = 0; v < `PITCH_VOICES; v++) keys[v] <= 8'hFF;
            for (int o = 0; o < `PITCH_OSCS; o++) begin
                for (int f = 0; f < 16; f++) begin
                    mem[o][f] <= (f == `PITCH_ADR_KS || !mapped(4'(f))) ? 8'h00 : 8'h40;
                end
            end
            pbr       <= 8'd3;
            exp_rdata <= 8'h00;
            rcnt      <= '0;
        end else begin
            if (rcnt != 3'd7) rcnt <= rcnt + 3'd1;
            if (note_on) keys[key_voice] <= key_val;
            if (wr && osc_sel && !adr.osc.num[2] && mapped(adr.osc.field))
                mem[adr.osc.num[1:0]][adr.osc.field] <= wdata;
            else if (wr && !osc_sel && com_sel && adr.com == 7'(`PITCH_ADR_PBR))
                pbr <= wdata;
            if (rd) begin
                if (osc_sel && !adr.osc.num[2] && mapped(adr.osc.field))
                    exp_rdata <= mem[adr.osc.num[1:0]][adr.osc.field];
                else if (!osc_sel && com_sel && adr.com == 7'(`PITCH_ADR_PBR))
                    exp_rdata <= pbr;
                else
                    exp_rdata <= 8'h00;
            end
        end
        exp_val[0]  <= expect_pitch(keys[slot.voice], cur_par, pbr, pitch_bend == 14'h0);
        exp_slot[0] <= slot;
        for (int i = 3; i > 0; i--) begin
            exp_val[i]  <= exp_val[i-1];
            exp_slot[i] <= exp_slot[i-1];
        end
        exp_chk  <= {exp_chk[2:0] & {3{!busy}}, cur_ok && !busy};
        exp_full <= {exp_full[2:0], started};
    end

    a_pitch: assert property (@(posedge sCLK_XVXOSC) disable iff (!started)
        exp_chk[3] |-> osc_pitch == exp_val[3])
        else begin
            $error("Error osc_pitch got %h expected %h",
                   $sampled(osc_pitch), $sampled(exp_val[3]));
            fail_cnt = fail_cnt + 1;
        end

    a_slot: assert property (@(posedge sCLK_XVXOSC) disable iff (!started)
        exp_full[3] |-> out_slot == exp_slot[3])
        else begin
            $error("Error out_slot got %h expected %h",
                   $sampled(out_slot), $sampled(exp_slot[3]));
            fail_cnt = fail_cnt + 1;
        end

    a_valid: assert property (@(posedge sCLK_XVXOSC) disable iff (!started)
        out_valid == (rcnt >= 3'd4))
        else begin
            $error("Error out_valid got %h expected %h",
                   $sampled(out_valid), $sampled(rcnt >= 3'd4));
            fail_cnt = fail_cnt + 1;
        end

    a_rdata: assert property (@(posedge sCLK_XVXOSC) disable iff (!started)
        rdata == exp_rdata)
        else begin
            $error("Error rdata got %h expected %h", $sampled(rdata), $sampled(exp_rdata));
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind pitch_control_top pitch_chk u_chk (.*);

/* bench/pitch_tb.sv */
`timescale 1ns/1ps
`include "pitch_macros.svh"

module pitch_tb;

    logic                   sCLK_XVXOSC;
    logic                   reset_data_N;
    logic                   osc_sel;
    logic                   com_sel;
    pitch_pkg::param_adr_u  adr;
    logic [7:0]             wdata;
    logic                   wr;
    logic                   rd;
    logic [`PITCH_V_W-1:0]  key_voice;
    logic [7:0]             key_val;
    logic                   note_on;
    pitch_pkg::slot_t       slot;
    logic [13:0]            pitch_bend;
    logic [7:0]             rdata;
    logic [23:0]            osc_pitch;
    pitch_pkg::slot_t       out_slot;
    logic                   out_valid;

    logic [15:0] lfsr = 16'd44;
    int          timeouts = 0;
    int          fields [5] = '{`PITCH_ADR_CT, `PITCH_ADR_FT, `PITCH_ADR_KS,
                                `PITCH_ADR_BCT, `PITCH_ADR_BFT};

    pitch_control_top dut (.*);

    initial begin
        sCLK_XVXOSC = 1'b0;
        forever #10 sCLK_XVXOSC = ~sCLK_XVXOSC;
    end

    task automatic tick();
        @(posedge sCLK_XVXOSC);
        #1;
    endtask

    // taps 16 14 13 11
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic write_reg(input logic os, input logic [6:0] a, input logic [7:0] d);
        osc_sel = os;
        com_sel = !os;
        adr     = a;
        wdata   = d;
        wr      = 1'b1;
        tick();
        wr = 1'b0;
    endtask

    task automatic read_reg(input logic os, input logic [6:0] a);
        osc_sel = os;
        com_sel = !os;
        adr     = a;
        rd      = 1'b1;
        tick();
        rd = 1'b0;
        tick();
    endtask

    task automatic restore_defaults();
        for (int o = 0; o < `PITCH_OSCS; o++) begin
            for (int i = 0; i < 5; i++) begin
                write_reg(1'b1, {1'b0, 2'(o), 4'(fields[i])},
                          (fields[i] == `PITCH_ADR_KS) ? 8'h00 : 8'h40);
            end
        end
        write_reg(1'b0, 7'(`PITCH_ADR_PBR), 8'd3);
    endtask

    task automatic run_slots(input int n);
        logic [7:0] v;
        logic [7:0] o;
        for (int i = 0; i < n; i++) begin
            v = rand_bits(3);
            o = rand_bits(2);
            slot = '{voice: v[2:0], osc: o[1:0]};
            tick();
        end
        repeat (5) tick();  // drain the pipeline
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (!out_valid && n < 20) begin
            tick();
            n++;
        end
        if (!out_valid) begin
            $display("out_valid never went high after reset");
            timeouts++;
        end
    endtask

    task automatic report(input int num, input string name);
        $display("test %0d %s done, assertion failures so far %0d",
                 num, name, dut.u_chk.fail_cnt);
    endtask

    initial begin
        logic [7:0] v;
        logic [7:0] k;
        reset_data_N = 1'b0;
        {osc_sel, com_sel, wr, rd, note_on} = '0;
        adr        = '0;
        wdata      = '0;
        key_voice  = '0;
        key_val    = '0;
        slot       = '0;
        pitch_bend = 14'h2000;  // center
        repeat (10) tick();
        reset_data_N = 1'b1;

        wait_valid();
        for (int o = 0; o < `PITCH_OSCS; o++) begin
            for (int i = 0; i < 5; i++) read_reg(1'b1, {1'b0, 2'(o), 4'(fields[i])});
        end
        read_reg(1'b0, 7'(`PITCH_ADR_PBR));
        report(1, "reset values");

        for (int o = 0; o < `PITCH_OSCS; o++) begin
            for (int i = 0; i < 5; i++) begin
                write_reg(1'b1, {1'b0, 2'(o), 4'(fields[i])}, 8'(8'h21 + 16 * o + i));
                read_reg(1'b1, {1'b0, 2'(o), 4'(fields[i])});
            end
        end
        write_reg(1'b0, 7'(`PITCH_ADR_PBR), 8'h07);
        read_reg(1'b0, 7'(`PITCH_ADR_PBR));
        read_reg(1'b1, 7'h03);
        read_reg(1'b0, 7'h03);
        restore_defaults();
        report(2, "register readback");

        for (int i = 0; i < 8; i++) begin
            v = rand_bits(3);
            k = rand_bits(7);
            key_voice = v[2:0];
            key_val   = k;
            note_on   = 1'b1;
            tick();
            note_on = 1'b0;
            run_slots(20);
        end
        report(3, "default pitch");

        write_reg(1'b1, {3'd0, 4'(`PITCH_ADR_BCT)}, 8'h3A);
        write_reg(1'b1, {3'd1, 4'(`PITCH_ADR_BCT)}, 8'h45);
        write_reg(1'b1, {3'd2, 4'(`PITCH_ADR_CT)}, 8'h42);
        write_reg(1'b1, {3'd3, 4'(`PITCH_ADR_CT)}, 8'h3E);
        write_reg(1'b1, {3'd3, 4'(`PITCH_ADR_KS)}, 8'h02);
        run_slots(60);
        restore_defaults();
        report(4, "coarse ratio and key scale");

        pitch_bend = 14'h0000;
        write_reg(1'b0, 7'(`PITCH_ADR_PBR), 8'd2);
        run_slots(32);
        write_reg(1'b0, 7'(`PITCH_ADR_PBR), 8'd5);
        run_slots(32);
        pitch_bend = 14'h2000;
        restore_defaults();
        report(5, "full bend down");

        for (int i = 0; i < 32; i++) begin
            slot = 5'(i);
            tick();
        end
        repeat (5) tick();
        report(6, "back to back slots");

        $display("tests 6, assertion failures %0d, timeouts %0d", dut.u_chk.fail_cnt, timeouts);
        if (dut.u_chk.fail_cnt == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+design
design/pitch_pkg.sv
design/key_table.sv
design/pitch_param_regs.sv
design/note_freq_rom.sv
design/pitch_calc.sv
design/pitch_control_top.sv
bench/pitch_chk.sv
bench/pitch_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the pitch testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pitch_tb -f src.f \
    -o pitch_sim > build.log 2>&1 &&
./obj_dir/pitch_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
